// ==== flist.f ====
+incdir+verif
source/isa_pkg.sv
source/lsu_pkg.sv
source/load_store_issue.sv
source/data_ram.sv
source/load_align.sv
source/lsu_top.sv
verif/lsu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module lsu_tb -o lsu_sim > build.log 2>&1 \
    && ./obj_dir/lsu_sim > sim.log 2>&1 \
    && grep -q "^Result: PASSED$" sim.log \
    && echo "Simulation ok" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== source/data_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input logic clk,
    input lsu_pkg::mem_req_t mem_req,
    output isa_pkg::word_t rdata
);

    import isa_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    word_t mem [DEPTH];
    logic [ADDR_WIDTH-1:0] idx;

    assign idx = mem_req.word_addr[ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (mem_req.wr) begin
            for (int i = 0; i < LANES; i++) begin
                if (mem_req.be[i]) begin
                    mem[idx][31 - 8*i -: 8] <= mem_req.wdata[31 - 8*i -: 8];
                end
            end
        end
        if (mem_req.rd) begin
            rdata <= mem[idx];              // Valid the cycle after rd
        end
    end

endmodule

`default_nettype wire

// ==== source/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    localparam int LANES = 4;

    typedef logic [31:0] word_t;        // Big-endian, lane 0 in bits 31:24
    typedef logic [15:0] half_t;
    typedef logic [7:0] byte_t;
    typedef logic [31:0] byte_addr_t;
    typedef logic [1:0] lane_t;         // Byte offset inside a word

    typedef enum logic [5:0] {
        OP_LB  = 6'b100000,
        OP_LH  = 6'b100001,
        OP_LWL = 6'b100010,
        OP_LW  = 6'b100011,
        OP_LBU = 6'b100100,
        OP_LHU = 6'b100101,
        OP_LWR = 6'b100110,
        OP_SB  = 6'b101000,
        OP_SH  = 6'b101001,
        OP_SW  = 6'b101011
    } opcode_t;

    // Lane 0 is the most significant byte
    function automatic byte_t word_lane(word_t w, lane_t lane);
        return w[31 - 8*lane -: 8];
    endfunction

endpackage

`default_nettype wire

// ==== source/load_align.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_align (
    input logic clk,
    input logic reset,
    input lsu_pkg::load_ctl_t load_ctl,
    input isa_pkg::word_t rdata,
    output logic load_valid,
    output isa_pkg::word_t load_data
);

    import isa_pkg::*;
    import lsu_pkg::*;

    load_ctl_t ctl_q;
    byte_t sel_byte;
    half_t sel_half;
    word_t merged;

    // Second stage so the controls line up with rdata
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_q <= '0;
        end else begin
            ctl_q <= load_ctl;
        end
    end

    assign load_valid = ctl_q.valid;

    always_comb begin
        sel_byte = word_lane(rdata, 2'd0);
        for (int i = 0; i < LANES; i++) begin
            if (ctl_q.be[i]) begin
                sel_byte = word_lane(rdata, lane_t'(i));
            end
        end
    end

    assign sel_half = ctl_q.be[0] ? rdata[31:16] : rdata[15:0];

    // Memory lane where enabled, old rt lane elsewhere
    always_comb begin
        merged = ctl_q.rt;
        for (int i = 0; i < LANES; i++) begin
            if (ctl_q.be[i]) begin
                merged[31 - 8*i -: 8] = word_lane(rdata, lane_t'(i));
            end
        end
    end

    always_comb begin
        case (ctl_q.op)
            OP_LB: begin
                load_data = {{24{sel_byte[7]}}, sel_byte};
            end
            OP_LBU: begin
                load_data = {24'd0, sel_byte};
            end
            OP_LH: begin
                load_data = {{16{sel_half[15]}}, sel_half};
            end
            OP_LHU: begin
                load_data = {16'd0, sel_half};
            end
            OP_LWL, OP_LWR: begin
                load_data = merged;
            end
            default: begin
                load_data = rdata;          // LW
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/load_store_issue.sv ====
`timescale 1ns/10ps
`default_nettype none

module load_store_issue #(
    parameter int ADDR_WIDTH = 8
) (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input isa_pkg::opcode_t req_op,
    input isa_pkg::byte_addr_t req_addr,
    input isa_pkg::word_t req_rt,
    output lsu_pkg::mem_req_t mem_req,
    output lsu_pkg::load_ctl_t load_ctl,
    output logic addr_error
);

    import isa_pkg::*;
    import lsu_pkg::*;

    lane_t offset;
    logic is_load;
    logic is_store;
    logic misaligned;
    logic accept;
    byte_en_t be_next;
    word_t wdata_next;

    assign offset = req_addr[1:0];

    always_comb begin
        is_load = 1'b0;
        is_store = 1'b0;
        misaligned = 1'b0;
        be_next = '0;
        wdata_next = req_rt;
        case (req_op)
            OP_LB, OP_LBU: begin
                is_load = 1'b1;
                be_next = BE_BYTE << offset;
            end
            OP_LH, OP_LHU: begin
                is_load = 1'b1;
                be_next = BE_HALF << offset;
                misaligned = offset[0];
            end
            OP_LW: begin
                is_load = 1'b1;
                be_next = BE_WORD;
                misaligned = (offset != 2'd0);
            end
            OP_LWL: begin
                is_load = 1'b1;
                be_next = BE_WORD << offset;        // Lanes k to 3
            end
            OP_LWR: begin
                is_load = 1'b1;
                be_next = BE_WORD >> (2'd3 - offset);   // Lanes 0 to k
            end
            OP_SB: begin
                is_store = 1'b1;
                be_next = BE_BYTE << offset;
                wdata_next = {4{req_rt[7:0]}};
            end
            OP_SH: begin
                is_store = 1'b1;
                be_next = BE_HALF << offset;
                misaligned = offset[0];
                wdata_next = {2{req_rt[15:0]}};
            end
            OP_SW: begin
                is_store = 1'b1;
                be_next = BE_WORD;
                misaligned = (offset != 2'd0);
            end
            default: ;                      // Unknown opcode, dropped
        endcase
    end

    assign accept = req_valid & (is_load | is_store) & ~misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            mem_req.rd <= 1'b0;
            mem_req.wr <= 1'b0;
            load_ctl.valid <= 1'b0;
            addr_error <= 1'b0;
        end else begin
            mem_req.rd <= accept & is_load;
            mem_req.wr <= accept & is_store;
            load_ctl.valid <= accept & is_load;
            addr_error <= req_valid & (is_load | is_store) & misaligned;
            if (req_valid) begin
                mem_req.word_addr <= 30'(req_addr[ADDR_WIDTH+1:2]);    // Wraps to RAM depth
                mem_req.be <= be_next;
                mem_req.wdata <= wdata_next;
                load_ctl.op <= req_op;
                load_ctl.be <= be_next;
                load_ctl.rt <= req_rt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    import isa_pkg::*;

    typedef logic [3:0] byte_en_t;      // Bit i enables lane i

    localparam byte_en_t BE_BYTE = 4'b0001;
    localparam byte_en_t BE_HALF = 4'b0011;
    localparam byte_en_t BE_WORD = 4'b1111;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [29:0] word_addr;         // RAM takes the low ADDR_WIDTH bits
        byte_en_t    be;
        word_t       wdata;             // Already in its lanes
    } mem_req_t;

    typedef struct packed {
        logic     valid;
        opcode_t  op;
        byte_en_t be;
        word_t    rt;                   // Old register value for merges
    } load_ctl_t;

endpackage

`default_nettype wire

// ==== source/lsu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_top #(
    parameter int ADDR_WIDTH = 8
) (
    input logic clk,
    input logic reset,
    input logic req_valid,
    input isa_pkg::opcode_t req_op,
    input isa_pkg::byte_addr_t req_addr,
    input isa_pkg::word_t req_rt,
    output logic load_valid,
    output isa_pkg::word_t load_data,
    output logic addr_error
);

    import isa_pkg::*;
    import lsu_pkg::*;

    mem_req_t mem_req;
    load_ctl_t load_ctl;
    word_t rdata;

    load_store_issue #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_load_store_issue (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_op(req_op),
        .req_addr(req_addr),
        .req_rt(req_rt),
        .mem_req(mem_req),
        .load_ctl(load_ctl),
        .addr_error(addr_error)
    );

    data_ram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_data_ram (
        .clk(clk),
        .mem_req(mem_req),
        .rdata(rdata)
    );

    load_align i_load_align (
        .clk(clk),
        .reset(reset),
        .load_ctl(load_ctl),
        .rdata(rdata),
        .load_valid(load_valid),
        .load_data(load_data)
    );

endmodule

`default_nettype wire

// ==== verif/lsu_model.svh ====
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

logic [7:0] shadow [0:4*(2**ADDR_WIDTH)-1];    // Word index times 4 plus lane

function automatic int slot(logic [31:0] addr, int lane);
    return int'(addr[ADDR_WIDTH+1:2]) * 4 + lane;
endfunction

function automatic bit known_op(opcode_t op);
    return op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
                      OP_SB, OP_SH, OP_SW};
endfunction

function automatic bit is_load_op(opcode_t op);
    return op inside {OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR};
endfunction

function automatic bit expect_error(opcode_t op, logic [31:0] addr);
    if (op inside {OP_LH, OP_LHU, OP_SH}) begin
        return addr[0];
    end
    if (op inside {OP_LW, OP_SW}) begin
        return addr[1:0] != 2'b00;
    end
    return 1'b0;
endfunction

function automatic logic [31:0] expect_load(opcode_t op, logic [31:0] addr, logic [31:0] rt);
    int k;
    logic [7:0] b;
    logic [15:0] h;
    logic [31:0] res;
    k = int'(addr[1:0]);
    b = shadow[slot(addr, k)];
    h = {b, shadow[slot(addr, k | 1)]};        // Only used when k is even
    res = rt;
    case (op)
        OP_LB: res = {{24{b[7]}}, b};
        OP_LBU: res = {24'd0, b};
        OP_LH: res = {{16{h[15]}}, h};
        OP_LHU: res = {16'd0, h};
        default: begin
            for (int i = 0; i < 4; i++) begin
                if (op == OP_LW || (op == OP_LWL && i >= k) || (op == OP_LWR && i <= k)) begin
                    res[31 - 8*i -: 8] = shadow[slot(addr, i)];
                end
            end
        end
    endcase
    return res;
endfunction

function automatic void apply_store(opcode_t op, logic [31:0] addr, logic [31:0] rt);
    int k;
    k = int'(addr[1:0]);
    case (op)
        OP_SB: shadow[slot(addr, k)] = rt[7:0];
        OP_SH: begin
            shadow[slot(addr, k)] = rt[15:8];
            shadow[slot(addr, k + 1)] = rt[7:0];
        end
        OP_SW: begin
            for (int i = 0; i < 4; i++) begin
                shadow[slot(addr, i)] = rt[31 - 8*i -: 8];
            end
        end
        default: ;
    endcase
endfunction

`endif

// ==== verif/lsu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lsu_tb;

    import isa_pkg::*;

    localparam int ADDR_WIDTH = 8;
    localparam int MIX_OPS = 300;
    localparam int LIMIT_CYCLES = 20 + 512 + 448 + 256 + 64 + MIX_OPS * 4 + 100;

    logic clk;
    logic reset;
    logic req_valid;
    opcode_t req_op;
    byte_addr_t req_addr;
    word_t req_rt;
    logic load_valid;
    word_t load_data;
    logic addr_error;

    int seed = 32'h63da;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int ncount = 0;                 // Falling edges seen
    int test_start;
    logic [31:0] exp_data[$];
    int exp_cyc[$];
    int err_cyc[$];
    opcode_t all_ops[10] = '{OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_LWR,
                             OP_SB, OP_SH, OP_SW};

    `include "lsu_model.svh"

    lsu_top #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) i_lsu_top (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_op(req_op),
        .req_addr(req_addr),
        .req_rt(req_rt),
        .load_valid(load_valid),
        .load_data(load_data),
        .addr_error(addr_error)
    );

    always #20 clk = ~clk;

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare(logic [31:0] actual, logic [31:0] expected, string msg);
        checks++;
        if (actual !== expected) begin
            $display("** Error at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Drives one strobe and queues the answers the model expects
    task automatic issue(opcode_t op, logic [31:0] addr, logic [31:0] rt);
        @(posedge clk);
        req_valid <= 1'b1;
        req_op <= op;
        req_addr <= addr;
        req_rt <= rt;
        if (expect_error(op, addr)) begin
            err_cyc.push_back(ncount + 2);
        end else if (known_op(op) && is_load_op(op)) begin
            exp_data.push_back(expect_load(op, addr, rt));
            exp_cyc.push_back(ncount + 3);
        end else if (known_op(op)) begin
            apply_store(op, addr, rt);
        end
    endtask

    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk);
            req_valid <= 1'b0;
        end
    endtask

    task automatic end_test(string name);
        idle(4);                    // Drain the pipeline
        tests++;
        $display("Test %0d %-14s %s (%0d errors)", tests, name,
                 (errors == test_start) ? "ok" : "failing", errors - test_start);
        test_start = errors;
    endtask

    always @(negedge clk) begin
        ncount = ncount + 1;
        if (!reset) begin
            if (load_valid) begin
                if (exp_cyc.size() == 0) begin
                    $display("Load result at %0t arrived with no load pending", $time);
                    errors++;
                end else begin
                    compare(32'(ncount), 32'(exp_cyc[0]), "load_valid cycle");
                    compare(load_data, exp_data[0], "load_data");
                    void'(exp_cyc.pop_front());
                    void'(exp_data.pop_front());
                end
            end else if (exp_cyc.size() != 0 && exp_cyc[0] <= ncount) begin
                $display("Load result expected at %0t never arrived", $time);
                errors++;
                void'(exp_cyc.pop_front());
                void'(exp_data.pop_front());
            end
            if (addr_error) begin
                if (err_cyc.size() == 0 || err_cyc[0] != ncount) begin
                    $display("Address error at %0t was not expected", $time);
                    errors++;
                end else begin
                    void'(err_cyc.pop_front());
                end
            end else if (err_cyc.size() != 0 && err_cyc[0] <= ncount) begin
                $display("Address error expected at %0t never came", $time);
                errors++;
                void'(err_cyc.pop_front());
            end
        end
    end

    initial begin
        #(LIMIT_CYCLES * 40);
        $display("Watchdog expired before the tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        int k;
        clk = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req_op = OP_LW;
        req_addr = '0;
        req_rt = '0;
        test_start = 0;

        repeat (10) begin
            @(negedge clk);
            compare(32'(load_valid), 32'd0, "load_valid in reset");
            compare(32'(addr_error), 32'd0, "addr_error in reset");
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare(32'(load_valid), 32'd0, "load_valid after reset");
        compare(32'(addr_error), 32'd0, "addr_error after reset");
        end_test("reset");

        for (int w = 0; w < 256; w++) begin
            issue(OP_SW, 32'(w * 4), $random(seed));
        end
        for (int w = 0; w < 256; w++) begin
            issue(OP_LW, 32'(w * 4), $random(seed));
        end
        end_test("fill_read");

        for (int w = 0; w < 32; w++) begin
            issue(OP_SB, 32'(w * 4 + rand_below(4)), $random(seed));
            issue(OP_SH, 32'(w * 4 + 2 * rand_below(2)), $random(seed));
        end
        for (int w = 0; w < 32; w++) begin
            for (int j = 0; j < 4; j++) begin
                issue(OP_LB, 32'(w * 4 + j), $random(seed));
                issue(OP_LBU, 32'(w * 4 + j), $random(seed));
                if (j % 2 == 0) begin
                    issue(OP_LH, 32'(w * 4 + j), $random(seed));
                    issue(OP_LHU, 32'(w * 4 + j), $random(seed));
                end
            end
        end
        end_test("partial");

        for (int w = 0; w < 32; w++) begin
            for (int j = 0; j < 4; j++) begin
                issue(OP_LWL, 32'(w * 4 + j), $random(seed));
                issue(OP_LWR, 32'(w * 4 + j), $random(seed));
            end
        end
        end_test("merge");

        for (int n = 0; n < 32; n++) begin
            k = rand_below(5);
            if (k < 3) begin
                issue(all_ops[k == 0 ? 1 : (k == 1 ? 5 : 8)],
                      32'(n * 4 + 1 + 2 * rand_below(2)), $random(seed));
            end else begin
                issue(k == 3 ? OP_LW : OP_SW, 32'(n * 4 + 1 + rand_below(3)), $random(seed));
            end
            issue(OP_LW, 32'(n * 4), $random(seed));   // Memory must be untouched
        end
        end_test("misaligned");

        for (int n = 0; n < MIX_OPS; n++) begin
            if (rand_below(16) == 0) begin
                issue(opcode_t'(6'b000111), 32'(rand_below(1024)), $random(seed));
            end else begin
                issue(all_ops[rand_below(10)], 32'(rand_below(1024)), $random(seed));
            end
            idle(rand_below(4));
        end
        end_test("random_mix");

        if (exp_cyc.size() != 0 || err_cyc.size() != 0) begin
            $display("%0d loads and %0d address errors were never seen",
                     exp_cyc.size(), err_cyc.size());
            errors++;
        end
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
